// File: all.f
verilog/xfer_pkg.sv
verilog/xfer_ifs.sv
verilog/setup_ctrl.sv
verilog/data_bank.sv
verilog/transfer_regs.sv
verilog/cmd_streamer.sv
verilog/run_monitor.sv
verilog/xfer_setup_top.sv
testbench/xfer_setup_tb.sv

// File: testbench/xfer_patterns.txt
// scenario count, then per scenario: slave rw ext addr0 addr1 cnt0 cnt1 rd0 rd1 (sw values)
// then word count and words for m0, the same for m1, beat count, beats as master kind data
0003
0004 0001 0000 0100 0200 0010 0000 0123 0abc
0000
0000
0006 0000 0000 0005 0000 0001 0100 0000 0002 0110
0001 0000 0008 0001 0001 0200 0001 0002 0200
000e 0002 0002 0700 07f0 0200 0005 07ff f0f0
0000
0003 beef 1234 00a5
0009 0000 0000 0011 0000 0001 0700 0000 0002 07ff
0001 0000 001f 0001 0001 07f0 0001 0002 07f5 0001 0003 beef 0001 0003 1234 0001 0003 00a5
0001 0003 0003 0f00 0010 0300 0020 0fff 8001
0002 1111 2222
0005 aaaa bbbb cccc dddd eeee
000d 0000 0000 000f 0000 0001 0f00 0000 0002 0fff 0000 0003 1111 0000 0003 2222
0001 0000 0007 0001 0001 0010 0001 0002 0030
0001 0003 aaaa 0001 0003 bbbb 0001 0003 cccc 0001 0003 dddd 0001 0003 eeee

// File: testbench/xfer_setup_tb.sv
`timescale 1ns/1ps

module xfer_setup_tb import xfer_pkg::*; ();

    localparam int          CLK_PERIOD      = 20;
    localparam int          DRIVE_DELAY     = 2;      // inputs change this long after posedge
    localparam int          CYCLES_PER_SCEN = 2000;
    localparam int          PAT_WORDS       = 256;
    localparam int          MAX_BEATS       = 64;
    localparam int          DELAY_TAB       = 128;
    localparam int unsigned RNG_SEED        = 32'hd006_f4c1;

    logic                    clk;
    logic                    rstN;
    logic                    step;
    logic                    next_word;
    data_t                   sw;
    logic                    cmd_credit;
    logic [MASTER_COUNT-1:0] done;
    setup_state_t            phase;
    logic                    cmd_valid;
    master_sel_t             cmd_master;
    beat_kind_t              cmd_kind;
    data_t                   cmd_data;
    logic [MASTER_COUNT-1:0] start;
    addr_t                   rd_addr;

    data_t        pat_mem [PAT_WORDS];
    int           pat_pos;
    int           delay_tab [DELAY_TAB];   // credit return delays in cycles
    data_t        s_slave, s_rw, s_ext;
    data_t        s_addr [MASTER_COUNT];
    data_t        s_cnt [MASTER_COUNT];
    data_t        s_rd [MASTER_COUNT];
    int           s_nwords [MASTER_COUNT];
    data_t        s_words [MASTER_COUNT][BANK_DEPTH];
    master_sel_t  exp_master [MAX_BEATS];
    beat_kind_t   exp_kind [MAX_BEATS];
    data_t        exp_data [MAX_BEATS];
    int           exp_total;
    int           beats_seen, outstanding, stall_cycles, start_hits;
    int           cycle_no, last_beat_cycle;
    setup_state_t prev_phase;

    xfer_setup_top i_dut (
        .clk, .rstN, .step, .next_word, .sw, .cmd_credit, .done,
        .phase, .cmd_valid, .cmd_master, .cmd_kind, .cmd_data, .start, .rd_addr
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run;
        $display("Errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_start(string name, logic [MASTER_COUNT-1:0] exp,
                               logic [MASTER_COUNT-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_master(string name, master_sel_t exp, master_sel_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_kind(string name, beat_kind_t exp, beat_kind_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_data(string name, data_t exp, data_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_state(string name, setup_state_t exp, setup_state_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic press_step(data_t v);
        next_cycle();
        sw   = v;
        step = 1'b1;
        next_cycle();
        step = 1'b0;
    endtask

    task automatic press_next(data_t v);
        next_cycle();
        sw        = v;
        next_word = 1'b1;
        next_cycle();
        next_word = 1'b0;
    endtask

    task automatic step_and_check(data_t v, setup_state_t exp);
        press_step(v);
        check_state("phase", exp, phase);
    endtask

    task automatic next_pat(output data_t v);
        v = pat_mem[pat_pos];
        pat_pos++;
    endtask

    task automatic load_scenario;
        data_t v;
        next_pat(s_slave);
        next_pat(s_rw);
        next_pat(s_ext);
        for (int m = 0; m < MASTER_COUNT; m++) next_pat(s_addr[m]);
        for (int m = 0; m < MASTER_COUNT; m++) next_pat(s_cnt[m]);
        for (int m = 0; m < MASTER_COUNT; m++) next_pat(s_rd[m]);
        for (int m = 0; m < MASTER_COUNT; m++) begin
            next_pat(v);
            s_nwords[m] = v;
            for (int k = 0; k < s_nwords[m]; k++) next_pat(s_words[m][k]);
        end
        next_pat(v);
        exp_total = v;
        for (int k = 0; k < exp_total; k++) begin
            next_pat(v);
            exp_master[k] = master_sel_t'(v);
            next_pat(v);
            exp_kind[k] = beat_kind_t'(v);
            next_pat(exp_data[k]);
        end
    endtask

    task automatic apply_reset;
        next_cycle();
        rstN      = 1'b0;
        step      = 1'b0;
        next_word = 1'b0;
        sw        = '0;
        done      = '0;
        repeat (3) @(posedge clk);
        #(DRIVE_DELAY);
        rstN = 1'b1;
        check_bit("cmd_valid", 1'b0, cmd_valid);
        check_start("start", '0, start);
        check_addr("rd_addr", '0, rd_addr);
        check_state("phase", ST_SLAVE_SEL, phase);
    endtask

    task automatic run_scenario;
        setup_state_t exp_ph;
        int           first, t_a, t_b;
        apply_reset();
        beats_seen = 0;
        start_hits = 0;
        step_and_check(s_slave, ST_RW_SEL);
        step_and_check(s_rw, ST_EXT_SEL);
        exp_ph = s_ext[0] ? ST_EXT_M0 : (s_ext[1] ? ST_EXT_M1 : ST_ADDR_M0);
        step_and_check(s_ext, exp_ph);
        if (s_ext[0]) begin
            for (int k = 0; k < s_nwords[0]; k++) press_next(s_words[0][k]);
            step_and_check('0, s_ext[1] ? ST_EXT_M1 : ST_ADDR_M0);
        end
        if (s_ext[1]) begin
            for (int k = 0; k < s_nwords[1]; k++) press_next(s_words[1][k]);
            step_and_check('0, ST_ADDR_M0);
        end
        step_and_check(s_addr[0], ST_ADDR_M1);
        step_and_check(s_addr[1], ST_COUNT_M0);
        step_and_check(s_cnt[0], ST_COUNT_M1);
        step_and_check(s_cnt[1], ST_CONFIG);
        while (phase !== ST_READY) @(negedge clk);   // beats are checked by the monitor

        step_and_check('0, ST_RUN);
        check_start("start", '1, start);
        next_cycle();
        check_start("start", '0, start);

        // done bits rise at separate random times in random order
        first = $urandom_range(0, 1);
        t_a   = $urandom_range(1, 8);
        t_b   = t_a + $urandom_range(1, 10);
        for (int c = 1; c <= t_b; c++) begin
            next_cycle();
            check_state("phase", ST_RUN, phase);
            if (c == t_a) done[first] = 1'b1;
            if (c == t_b) done[1 - first] = 1'b1;
        end
        next_cycle();
        check_state("phase", ST_RUN, phase);      // done bits latched on this edge
        next_cycle();
        check_state("phase", ST_FINISHED, phase);
        if (start_hits != 1) begin
            $display("start was high in %0d cycles instead of one", start_hits);
            abort_run();
        end

        check_addr("rd_addr", '0, rd_addr);
        for (int m = 0; m < MASTER_COUNT; m++) begin
            press_next(s_rd[m]);
            check_addr("rd_addr", addr_t'(s_rd[m][ADDR_W-1:0]), rd_addr);
        end
        check_state("phase", ST_FINISHED, phase);
    endtask

    // receiver model that hands back one credit per buffered beat after a random wait
    initial begin : credit_return
        int dly_pos;
        int wait_left;
        dly_pos    = 0;
        wait_left  = 0;
        cmd_credit = 1'b0;
        forever begin
            next_cycle();
            if (outstanding > 0 && wait_left == 0) begin
                cmd_credit = 1'b1;
                wait_left  = delay_tab[dly_pos % DELAY_TAB];
                dly_pos++;
            end else begin
                cmd_credit = 1'b0;
                if (wait_left > 0) wait_left--;
            end
        end
    end

    // sampled mid-cycle where all outputs are settled
    initial begin : beat_monitor
        logic exp_valid;
        beats_seen      = 0;
        outstanding     = 0;
        stall_cycles    = 0;
        start_hits      = 0;
        cycle_no        = 0;
        last_beat_cycle = 0;
        prev_phase      = ST_SLAVE_SEL;
        forever begin
            @(negedge clk);
            cycle_no++;
            if (rstN !== 1'b1) begin
                outstanding = 0;
            end else begin
                exp_valid = (phase == ST_CONFIG) && (beats_seen < exp_total) &&
                            (outstanding < CREDIT_MAX);
                check_bit("cmd_valid", exp_valid, cmd_valid);
                if (phase == ST_CONFIG && beats_seen < exp_total && outstanding >= CREDIT_MAX)
                    stall_cycles++;
                if (cmd_valid) begin
                    check_master("cmd_master", exp_master[beats_seen], cmd_master);
                    check_kind("cmd_kind", exp_kind[beats_seen], cmd_kind);
                    check_data("cmd_data", exp_data[beats_seen], cmd_data);
                    beats_seen++;
                    last_beat_cycle = cycle_no;
                end
                if (start != '0) start_hits++;
                if (phase == ST_READY && prev_phase == ST_CONFIG) begin
                    if (beats_seen != exp_total) begin
                        $display("stream ended after %0d beats, %0d expected",
                                 beats_seen, exp_total);
                        abort_run();
                    end
                    if (cycle_no != last_beat_cycle + 2) begin
                        $display("ready phase came %0d cycles after the last beat",
                                 cycle_no - last_beat_cycle);
                        abort_run();
                    end
                end
                outstanding = outstanding + (cmd_valid ? 1 : 0) - (cmd_credit ? 1 : 0);
            end
            prev_phase = phase;
        end
    end

    initial begin : watchdog
        int n;
        #1;
        n = pat_mem[0];
        if (n < 1) n = 1;
        #(n * CYCLES_PER_SCEN * CLK_PERIOD);
        $display("timeout, the scenarios did not complete in time");
        abort_run();
    end

    initial begin : main_seq
        int n_scen;
        rstN      = 1'b0;
        step      = 1'b0;
        next_word = 1'b0;
        sw        = '0;
        done      = '0;
        exp_total = 0;
        void'($urandom(RNG_SEED));
        for (int i = 0; i < DELAY_TAB; i++) delay_tab[i] = $urandom_range(0, 7);
        $readmemh("testbench/xfer_patterns.txt", pat_mem);
        if ((^pat_mem[0] === 1'bx) || pat_mem[0] == '0) begin
            $display("pattern file is missing or holds no scenario");
            abort_run();
        end
        n_scen  = pat_mem[0];
        pat_pos = 1;
        for (int i = 0; i < n_scen; i++) begin
            load_scenario();
            run_scenario();
            $display("scenario %0d complete, %0d beats", i, beats_seen);
        end
        if (stall_cycles > 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("the receiver never held back credits long enough to stall the stream");
            abort_run();
        end
    end

endmodule : xfer_setup_tb

// File: verilog/xfer_setup_top.sv
`timescale 1ns/1ps

module xfer_setup_top import xfer_pkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    step,
    input  logic                    next_word,
    input  data_t                   sw,
    input  logic                    cmd_credit,
    input  logic [MASTER_COUNT-1:0] done,
    output setup_state_t            phase,
    output logic                    cmd_valid,
    output master_sel_t             cmd_master,
    output beat_kind_t              cmd_kind,
    output data_t                   cmd_data,
    output logic [MASTER_COUNT-1:0] start,
    output addr_t                   rd_addr
);

    logic                    stream_done;
    logic                    both_done;
    logic [MASTER_COUNT-1:0] ext_pending;

    xfer_cfg_if cfg_if ();
    bank_rd_if  rd_if ();

    setup_ctrl i_setup_ctrl (.clk, .rstN, .step, .sw, .stream_done, .both_done,
                             .phase, .ext_pending);

    data_bank i_data_bank (.clk, .rstN, .phase, .next_word, .sw, .rd(rd_if.bank));

    transfer_regs i_transfer_regs (.clk, .rstN, .phase, .step, .sw, .ext_pending,
                                   .cfg(cfg_if.src));

    cmd_streamer i_cmd_streamer (.clk, .rstN, .phase, .cmd_credit,
                                 .cfg(cfg_if.sink), .rd(rd_if.reader),
                                 .cmd_valid, .cmd_master, .cmd_kind, .cmd_data, .stream_done);

    run_monitor i_run_monitor (.clk, .rstN, .phase, .step, .next_word, .sw, .done,
                               .start, .both_done, .rd_addr);

endmodule : xfer_setup_top

// File: verilog/run_monitor.sv
`timescale 1ns/1ps

module run_monitor import xfer_pkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  setup_state_t            phase,
    input  logic                    step,
    input  logic                    next_word,
    input  data_t                   sw,
    input  logic [MASTER_COUNT-1:0] done,
    output logic [MASTER_COUNT-1:0] start,
    output logic                    both_done,
    output addr_t                   rd_addr
);

    logic [MASTER_COUNT-1:0] done_seen;   // sticky per master
    logic                    go;

    assign go        = step && (phase == ST_READY);
    assign both_done = &done_seen;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            start     <= '0;
            done_seen <= '0;
            rd_addr   <= '0;
        end else begin
            start <= {MASTER_COUNT{go}};   // single cycle pulse to both masters together
            if (go) done_seen <= '0;
            else if (phase == ST_RUN) done_seen <= done_seen | done;
            if (phase == ST_FINISHED && next_word) begin
                rd_addr <= sw[ADDR_W-1:0];
            end
        end
    end

    a_start_pulse: assert property (
        @(posedge clk) disable iff (!rstN)
        (start != '0) |=> (start == '0)
    ) else $error("start held for more than one cycle");

endmodule : run_monitor

// File: verilog/cmd_streamer.sv
`timescale 1ns/1ps

module cmd_streamer import xfer_pkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  setup_state_t phase,
    input  logic         cmd_credit,
    xfer_cfg_if.sink     cfg,
    bank_rd_if.reader    rd,
    output logic         cmd_valid,
    output master_sel_t  cmd_master,
    output beat_kind_t   cmd_kind,
    output data_t        cmd_data,
    output logic         stream_done
);

    master_sel_t m;
    beat_kind_t  kind;
    bank_ptr_t   idx;
    logic        fin;        // every beat of both masters sent
    credit_t     credit;
    logic        has_data;
    logic        last_word;
    logic        mst_end;    // this beat closes the current master

    assign has_data  = cfg.ext[m] && (rd.count != '0);
    assign last_word = (bank_cnt_t'(idx) + bank_cnt_t'(1)) == rd.count;
    assign mst_end   = cmd_valid && ((kind == BEAT_LAST && !has_data) ||
                                     (kind == BEAT_DATA && last_word));

    assign cmd_valid  = (phase == ST_CONFIG) && !fin && (credit != '0);
    assign cmd_master = m;
    assign cmd_kind   = kind;
    assign rd.sel     = m;
    assign rd.idx     = idx;

    always_comb begin
        unique case (kind)
            BEAT_HDR:   cmd_data = DATA_W'({cfg.slave_id[m], cfg.wr[m], cfg.ext[m], cfg.burst[m]});
            BEAT_FIRST: cmd_data = DATA_W'(cfg.first_addr[m]);
            BEAT_LAST:  cmd_data = DATA_W'(cfg.last_addr[m]);
            default:    cmd_data = rd.word;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            m <= '0;
            kind <= BEAT_HDR;
            idx <= '0;
            fin <= 1'b0;
            stream_done <= 1'b0;
        end else if (phase != ST_CONFIG) begin
            m <= '0;             // rearm for the next config pass
            kind <= BEAT_HDR;
            idx <= '0;
            fin <= 1'b0;
            stream_done <= 1'b0;
        end else begin
            stream_done <= mst_end && (m == master_sel_t'(MASTER_COUNT - 1));
            if (mst_end && m == master_sel_t'(MASTER_COUNT - 1)) begin
                fin <= 1'b1;
            end else if (mst_end) begin
                m    <= m + 1'b1;
                kind <= BEAT_HDR;
                idx  <= '0;
            end else if (cmd_valid) begin
                unique case (kind)
                    BEAT_HDR:   kind <= BEAT_FIRST;
                    BEAT_FIRST: kind <= BEAT_LAST;
                    BEAT_LAST:  kind <= BEAT_DATA;   // idx already at 0
                    default:    idx  <= idx + 1'b1;
                endcase
            end
        end
    end

    // one credit per beat and one back per return pulse
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            credit <= credit_t'(CREDIT_MAX);
        end else if (cmd_valid && !cmd_credit) begin
            credit <= credit - 1'b1;
        end else if (cmd_credit && !cmd_valid) begin
            credit <= credit + 1'b1;
        end
    end

    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rstN)
        (credit <= credit_t'(CREDIT_MAX)) &&
        !(cmd_credit && !cmd_valid && credit == credit_t'(CREDIT_MAX))
    ) else $error("credit counter out of range, credit=%0d", credit);

endmodule : cmd_streamer

// File: verilog/transfer_regs.sv
`timescale 1ns/1ps

module transfer_regs import xfer_pkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  setup_state_t            phase,
    input  logic                    step,
    input  data_t                   sw,
    input  logic [MASTER_COUNT-1:0] ext_pending,
    xfer_cfg_if.src                 cfg
);

    master_sel_t     cm;         // master addressed by the current addr/count state
    addr_t           sw_addr;
    addr_t           limit;
    logic [ADDR_W:0] sum;        // one spare bit for the carry
    addr_t           last_clamped;

    function automatic int depth_of(slave_id_t id);
        return (id == 2'd3) ? SLAVE_DEPTHS[2] : SLAVE_DEPTHS[id];
    endfunction

    assign cm      = master_sel_t'(phase == ST_ADDR_M1 || phase == ST_COUNT_M1);
    assign sw_addr = sw[ADDR_W-1:0];
    assign limit   = addr_t'(depth_of(cfg.slave_id[cm]) - 1);
    assign sum     = {1'b0, cfg.first_addr[cm]} + {1'b0, sw_addr};
    assign last_clamped = (sum > {1'b0, limit}) ? limit : sum[ADDR_W-1:0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg.slave_id <= '{default: '0};
            cfg.wr       <= '0;
            cfg.ext      <= '0;
            cfg.burst    <= '0;
        end else if (step) begin
            unique case (phase)
                ST_SLAVE_SEL: begin
                    cfg.slave_id[0] <= sw[1:0];
                    cfg.slave_id[1] <= sw[3:2];
                end
                ST_RW_SEL:   cfg.wr  <= sw[MASTER_COUNT-1:0];
                ST_ADDR_M0:  cfg.ext <= ext_pending;     // ext choice is settled by now
                ST_COUNT_M0,
                ST_COUNT_M1: cfg.burst[cm] <= (sw_addr != '0);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (step && (phase == ST_ADDR_M0 || phase == ST_ADDR_M1)) begin
            cfg.first_addr[cm] <= sw_addr;
        end
        if (step && (phase == ST_COUNT_M0 || phase == ST_COUNT_M1)) begin
            cfg.last_addr[cm] <= last_clamped;   // capped at slave depth - 1
        end
    end

endmodule : transfer_regs

// File: verilog/data_bank.sv
`timescale 1ns/1ps

module data_bank import xfer_pkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  setup_state_t phase,
    input  logic         next_word,
    input  data_t        sw,
    bank_rd_if.bank      rd
);

    data_t       mem   [MASTER_COUNT][BANK_DEPTH];
    bank_cnt_t   count [MASTER_COUNT];
    master_sel_t wr_sel;
    bank_ptr_t   wr_ptr;
    logic        wr_en;

    assign wr_sel = master_sel_t'(phase == ST_EXT_M1);
    assign wr_ptr = bank_ptr_t'(count[wr_sel]);   // next free slot
    assign wr_en  = next_word && (phase == ST_EXT_M0 || phase == ST_EXT_M1) &&
                    (count[wr_sel] < bank_cnt_t'(BANK_DEPTH));   // full bank drops words

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_sel][wr_ptr] <= sw;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '{default: '0};
        end else if (wr_en) begin
            count[wr_sel] <= count[wr_sel] + 1'b1;
        end
    end

    assign rd.word  = mem[rd.sel][rd.idx];
    assign rd.count = count[rd.sel];

    // streamer must stay inside the words actually entered
    a_rd_in_range: assert property (
        @(posedge clk) disable iff (!rstN)
        (phase == ST_CONFIG && rd.count != '0) |-> (bank_cnt_t'(rd.idx) < rd.count)
    ) else $error("bank read index %0d beyond count %0d", rd.idx, rd.count);

endmodule : data_bank

// File: verilog/setup_ctrl.sv
`timescale 1ns/1ps

module setup_ctrl import xfer_pkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    step,
    input  data_t                   sw,
    input  logic                    stream_done,
    input  logic                    both_done,
    output setup_state_t            phase,
    output logic [MASTER_COUNT-1:0] ext_pending
);

    setup_state_t state_nxt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase       <= ST_SLAVE_SEL;
            ext_pending <= '0;
        end else begin
            phase <= state_nxt;
            if (step && phase == ST_EXT_SEL) begin
                ext_pending <= sw[MASTER_COUNT-1:0];  // masters that take entered data
            end
        end
    end

    always_comb begin
        state_nxt = phase;
        unique case (phase)
            ST_SLAVE_SEL: begin
                if (step) state_nxt = ST_RW_SEL;
            end
            ST_RW_SEL: begin
                if (step) state_nxt = ST_EXT_SEL;
            end
            ST_EXT_SEL: begin
                if (step) begin
                    unique case (sw[1:0])
                        2'b00:   state_nxt = ST_ADDR_M0;
                        2'b10:   state_nxt = ST_EXT_M1;
                        default: state_nxt = ST_EXT_M0;  // 01 and 11 start with master 0
                    endcase
                end
            end
            ST_EXT_M0: begin
                if (step) begin
                    state_nxt = (ext_pending == 2'b11) ? ST_EXT_M1 : ST_ADDR_M0;
                end
            end
            ST_EXT_M1: begin
                if (step) state_nxt = ST_ADDR_M0;
            end
            ST_ADDR_M0: begin
                if (step) state_nxt = ST_ADDR_M1;
            end
            ST_ADDR_M1: begin
                if (step) state_nxt = ST_COUNT_M0;
            end
            ST_COUNT_M0: begin
                if (step) state_nxt = ST_COUNT_M1;
            end
            ST_COUNT_M1: begin
                if (step) state_nxt = ST_CONFIG;
            end
            ST_CONFIG: begin
                // left on its own once the streamer has sent everything
                if (stream_done) state_nxt = ST_READY;
            end
            ST_READY: begin
                if (step) state_nxt = ST_RUN;
            end
            ST_RUN: begin
                if (both_done) state_nxt = ST_FINISHED;
            end
            ST_FINISHED: begin
                state_nxt = ST_FINISHED;   // held until reset
            end
            default: begin
                state_nxt = ST_SLAVE_SEL;
            end
        endcase
    end

    // the streamer may only finish while configuration is under way
    a_done_in_config: assert property (
        @(posedge clk) disable iff (!rstN)
        stream_done |-> phase == ST_CONFIG
    ) else $error("stream_done outside ST_CONFIG");

endmodule : setup_ctrl

// File: verilog/xfer_ifs.sv
`timescale 1ns/1ps

// per-master transfer settings held steady through the config phase
interface xfer_cfg_if import xfer_pkg::*; ();
    slave_id_t                slave_id   [MASTER_COUNT];
    logic [MASTER_COUNT-1:0]  wr;        // 1 = write
    logic [MASTER_COUNT-1:0]  ext;       // use words from the data bank
    logic [MASTER_COUNT-1:0]  burst;
    addr_t                    first_addr [MASTER_COUNT];
    addr_t                    last_addr  [MASTER_COUNT];

    modport src (
        output slave_id, wr, ext, burst, first_addr, last_addr
    );

    modport sink (
        input  slave_id, wr, ext, burst, first_addr, last_addr
    );
endinterface : xfer_cfg_if

// combinational read port into the external data bank
interface bank_rd_if import xfer_pkg::*; ();
    master_sel_t sel;
    bank_ptr_t   idx;
    data_t       word;
    bank_cnt_t   count;    // words stored for sel

    modport bank (
        input  sel, idx,
        output word, count
    );

    modport reader (
        output sel, idx,
        input  word, count
    );
endinterface : bank_rd_if

// File: verilog/xfer_pkg.sv
package xfer_pkg;

    localparam int MASTER_COUNT = 2;
    localparam int DATA_W       = 16;
    localparam int ADDR_W       = 12;    // covers the deepest slave
    localparam int BANK_DEPTH   = 16;    // external words per master
    localparam int CREDIT_MAX   = 4;     // receiver buffer size in beats

    // depth per slave id where reserved id 3 maps onto the last entry
    localparam int SLAVE_DEPTHS [3] = '{4096, 4096, 2048};

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [1:0]        slave_id_t;
    typedef logic [4:0]        bank_cnt_t;     // 0 .. 16
    typedef logic [3:0]        bank_ptr_t;
    typedef logic [2:0]        credit_t;       // 0 .. 4
    typedef logic [0:0]        master_sel_t;

    typedef enum logic [3:0] {
        ST_SLAVE_SEL,
        ST_RW_SEL,
        ST_EXT_SEL,
        ST_EXT_M0,
        ST_EXT_M1,
        ST_ADDR_M0,
        ST_ADDR_M1,
        ST_COUNT_M0,
        ST_COUNT_M1,
        ST_CONFIG,
        ST_READY,
        ST_RUN,
        ST_FINISHED
    } setup_state_t;

    typedef enum logic [1:0] {BEAT_HDR, BEAT_FIRST, BEAT_LAST, BEAT_DATA} beat_kind_t;

endpackage : xfer_pkg
